/* hw/diskGeomPkg.sv */
package diskGeomPkg;

	// Word index layout is {track, sector, word}.
	localparam int TrackBits = 2;
	localparam int SectorBits = 3;
	localparam int WordBits = 5;
	localparam int DiskAddrBits = TrackBits + SectorBits + WordBits;
	localparam int DiskWords = 1 << DiskAddrBits;

	typedef logic [DiskAddrBits-1:0] diskAddrT;
	typedef logic [31:0] diskWordT;

	localparam int BootWords = 16;

	// Entry 0 is the image length in words.
	localparam diskWordT BootImage [0:BootWords-1] = '{
		diskWordT'(BootWords),
		32'h0000_012c,
		32'h7000_0000,
		32'hb100_0000,
		32'h7f00_0000,
		32'h7d80_0fff,
		32'h6000_3401,
		32'h15d6_8002,
		32'h80d0_3200,
		32'h4000_0077,
		32'h60d0_33fe,
		32'h60d0_29ff,
		32'h42a0_0000,
		32'h60d8_3001,
		32'h15de_c001,
		32'h19c6_3000
	};

endpackage

/* hw/diskBusPkg.sv */
package diskBusPkg;

	localparam int AxiAddrBits = 32;
	localparam int AxiDataBits = 32;

	typedef logic [AxiAddrBits-1:0] axiAddrT;
	typedef logic [AxiDataBits-1:0] axiDataT;
	typedef logic [AxiDataBits/8-1:0] axiStrbT;
	typedef logic [1:0] axiRespT;

	localparam axiRespT RespOkay = 2'b00;
	localparam axiRespT RespSlvErr = 2'b10;
	localparam axiRespT RespDecErr = 2'b11;

	// ReadWait covers the first cycle of the two-cycle store read.
	typedef enum logic [1:0] {
		Idle,
		WriteResp,
		ReadWait,
		ReadResp
	} busStateT;

endpackage

/* hw/diskReqIf.sv */
`timescale 1ns/100ps

interface diskReqIf;
	import diskGeomPkg::*;

	// A request lasts one cycle and is only issued while ready is high.
	logic req;
	logic write;
	diskAddrT addr;
	diskWordT wdata;

	// Read data shows up two cycles after the request and is held until the next read.
	diskWordT rdata;
	logic ready;

	modport host (
		output req, write, addr, wdata,
		input rdata, ready
	);

	modport store (
		input req, write, addr, wdata,
		output rdata, ready
	);

endinterface

/* hw/bootImageRom.sv */
`timescale 1ns/100ps

module bootImageRom (
	input logic clk,
	input diskGeomPkg::diskAddrT addr,
	output diskGeomPkg::diskWordT data
);
	import diskGeomPkg::*;

	localparam int BootIdxBits = $clog2(BootWords);

	logic inImage;

	assign inImage = (addr < diskAddrT'(BootWords));

	// Everything past the boot image reads as zero from the factory.
	always_ff @(posedge clk)
	begin
		if (inImage)
			data <= BootImage[addr[BootIdxBits-1:0]];
		else
			data <= '0;
	end

endmodule

/* hw/writtenMap.sv */
`timescale 1ns/100ps

module writtenMap (
	input logic clk,
	input logic rst,
	input logic setEn,
	input diskGeomPkg::diskAddrT setAddr,
	input diskGeomPkg::diskAddrT lookAddr,
	output logic written,
	output logic clearDone
);
	import diskGeomPkg::*;

	typedef enum logic {
		Clearing,
		Ready
	} mapStateT;

	mapStateT state;
	diskAddrT clearAddr;
	logic flags [DiskWords];

	// One flag is cleared per cycle, so the sweep takes DiskWords cycles.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= Clearing;
			clearAddr <= '0;
		end
		else if (state == Clearing)
		begin
			clearAddr <= clearAddr + 1'b1;
			if (clearAddr == diskAddrT'(DiskWords - 1))
				state <= Ready;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == Clearing)
			flags[clearAddr] <= 1'b0;
		else if (setEn)
			flags[setAddr] <= 1'b1;
		written <= flags[lookAddr];
	end

	assign clearDone = (state == Ready);

	assert property (@(posedge clk) disable iff (rst) !(setEn && state == Clearing));

endmodule

/* hw/sectorStore.sv */
`timescale 1ns/100ps

module sectorStore (
	input logic clk,
	input logic rst,
	diskReqIf.store disk
);
	import diskGeomPkg::*;

	diskWordT ram [DiskWords];
	diskWordT ramWord;
	diskWordT romWord;
	logic written;
	logic clearDone;
	logic setEn;
	logic readPend;

	assign setEn = disk.req && disk.write;
	assign disk.ready = clearDone;

	writtenMap u_writtenMap (
		.clk(clk),
		.rst(rst),
		.setEn(setEn),
		.setAddr(disk.addr),
		.lookAddr(disk.addr),
		.written(written),
		.clearDone(clearDone)
	);

	bootImageRom u_bootImageRom (
		.clk(clk),
		.addr(disk.addr),
		.data(romWord)
	);

	always_ff @(posedge clk)
	begin
		if (setEn)
			ram[disk.addr] <= disk.wdata;
		ramWord <= ram[disk.addr];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			readPend <= 1'b0;
		else
			readPend <= disk.req && !disk.write;
	end

	// Stored data overlays the factory image word by word.
	always_ff @(posedge clk)
	begin
		if (readPend)
			disk.rdata <= written ? ramWord : romWord;
	end

	assert property (@(posedge clk) disable iff (rst) disk.req |-> disk.ready);

endmodule

/* hw/axiLiteSlave.sv */
`timescale 1ns/100ps

module axiLiteSlave (
	input logic clk,
	input logic rst,
	input diskBusPkg::axiAddrT awaddr,
	input logic awvalid,
	output logic awready,
	input diskBusPkg::axiDataT wdata,
	input diskBusPkg::axiStrbT wstrb,
	input logic wvalid,
	output logic wready,
	output diskBusPkg::axiRespT bresp,
	output logic bvalid,
	input logic bready,
	input diskBusPkg::axiAddrT araddr,
	input logic arvalid,
	output logic arready,
	output diskBusPkg::axiDataT rdata,
	output diskBusPkg::axiRespT rresp,
	output logic rvalid,
	input logic rready,
	diskReqIf.host disk
);
	import diskGeomPkg::*;
	import diskBusPkg::*;

	localparam axiAddrT DiskBytes = axiAddrT'(DiskWords * 4);

	busStateT state;
	logic acceptWrite;
	logic acceptRead;
	logic writeAddrOk;
	logic readAddrOk;
	logic strbOk;

	function automatic logic addrOk(axiAddrT a);
		return (a < DiskBytes) && (a[1:0] == 2'b00);
	endfunction

	assign writeAddrOk = addrOk(awaddr);
	assign readAddrOk = addrOk(araddr);
	assign strbOk = &wstrb; // Partial writes are not supported.

	// A write needs both its address and data; it wins over a pending read.
	assign acceptWrite = (state == Idle) && disk.ready && awvalid && wvalid;
	assign acceptRead = (state == Idle) && disk.ready && arvalid && !(awvalid && wvalid);

	assign awready = acceptWrite;
	assign wready = acceptWrite;
	assign arready = acceptRead;

	// Refused and out-of-range transactions never reach the store.
	assign disk.req = (acceptWrite && writeAddrOk && strbOk) || (acceptRead && readAddrOk);
	assign disk.write = acceptWrite;
	assign disk.addr = acceptWrite ? awaddr[DiskAddrBits+1:2] : araddr[DiskAddrBits+1:2];
	assign disk.wdata = diskWordT'(wdata);

	assign bvalid = (state == WriteResp);
	assign rvalid = (state == ReadResp);
	assign rdata = (rresp == RespOkay) ? axiDataT'(disk.rdata) : '0;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= Idle;
		else
		begin
			case (state)
				Idle:
				begin
					if (acceptWrite)
						state <= WriteResp;
					else if (acceptRead)
						state <= ReadWait;
				end
				WriteResp:
				begin
					if (bready)
						state <= Idle;
				end
				ReadWait:
					state <= ReadResp; // Store data lands during this cycle.
				ReadResp:
				begin
					if (rready)
						state <= Idle;
				end
				default:
					state <= Idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (acceptWrite)
		begin
			if (!writeAddrOk)
				bresp <= RespDecErr;
			else if (!strbOk)
				bresp <= RespSlvErr;
			else
				bresp <= RespOkay;
		end
		if (acceptRead)
			rresp <= readAddrOk ? RespOkay : RespDecErr;
	end

	// The write response holds until the master takes it.
	assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

/* hw/diskTop.sv */
`timescale 1ns/100ps

module diskTop (
	input logic clk,
	input logic rst,
	input diskBusPkg::axiAddrT awaddr,
	input logic awvalid,
	output logic awready,
	input diskBusPkg::axiDataT wdata,
	input diskBusPkg::axiStrbT wstrb,
	input logic wvalid,
	output logic wready,
	output diskBusPkg::axiRespT bresp,
	output logic bvalid,
	input logic bready,
	input diskBusPkg::axiAddrT araddr,
	input logic arvalid,
	output logic arready,
	output diskBusPkg::axiDataT rdata,
	output diskBusPkg::axiRespT rresp,
	output logic rvalid,
	input logic rready
);

	diskReqIf disk ();

	axiLiteSlave u_axiLiteSlave (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.disk(disk.host)
	);

	sectorStore u_sectorStore (
		.clk(clk),
		.rst(rst),
		.disk(disk.store)
	);

endmodule

/* tests/tbClock.sv */
`timescale 1ns/100ps

module tbClock (
	input logic resetReq,
	output logic clk,
	output logic rst
);
	int rstCycles = 3; // Reset holds for three rising edges.

	initial
		clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period.

	assign rst = (rstCycles != 0);

	always @(posedge clk)
	begin
		if (resetReq)
			rstCycles <= 3;
		else if (rstCycles != 0)
			rstCycles <= rstCycles - 1;
	end

endmodule

/* tests/diskTb.sv */
`timescale 1ns/100ps

module diskTb;
	import diskGeomPkg::*;
	import diskBusPkg::*;

	// Each test phase gets this many cycles before the watchdog fires.
	localparam int PhaseCycles = 5000;
	localparam int TestPhases = 5;

	logic clk, rst, resetReq;
	axiAddrT awaddr, araddr;
	axiDataT wdata, rdata, expRdata;
	axiStrbT wstrb;
	axiRespT bresp, rresp, expBresp, expRresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	diskWordT model [int]; // Words written since the last reset.
	int touched [$];

	tbClock u_tbClock (.resetReq(resetReq), .clk(clk), .rst(rst));
	diskTop u_diskTop (.*);

	function automatic void abortRun(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1);
	endfunction

	// Unwritten words read back as the factory image.
	function automatic diskWordT modelRead(input int idx);
		if (model.exists(idx))
			return model[idx];
		return (idx < BootWords) ? BootImage[idx[3:0]] : '0;
	endfunction

	task automatic busTransfer(input bit isRead, input axiAddrT a, input axiDataT d,
			input axiStrbT s, input int hold);
		axiRespT resp;
		resp = (a >= 32'd4096 || a[1:0] != 2'b00) ? RespDecErr : RespOkay;
		if (!isRead && resp == RespOkay && s != 4'hf)
			resp = RespSlvErr;
		@(posedge clk);
		// The idle address channel carries the complement, an out-of-range address.
		{awaddr, araddr, wdata, wstrb} <= {isRead ? ~a : a, isRead ? a : ~a, d, s};
		{awvalid, wvalid, arvalid} <= {!isRead, !isRead, isRead};
		{rready, bready} <= {2{hold == 0}};
		{expBresp, expRresp} <= {resp, resp};
		expRdata <= (resp == RespOkay) ? modelRead(int'(a >> 2)) : '0;
		if (!isRead && resp == RespOkay)
			model[int'(a >> 2)] = d;
		@(negedge clk);
		while (!(arready || awready))
			@(negedge clk);
		@(posedge clk);
		{awvalid, wvalid, arvalid} <= 3'b000;
		@(negedge clk);
		while (!(rvalid || bvalid))
			@(negedge clk);
		if (hold > 0)
		begin
			repeat (hold) @(posedge clk); // Back-pressure on the response.
			{rready, bready} <= 2'b11;
		end
		@(posedge clk);
	endtask

	assert property (@(posedge clk) disable iff (rst)
		rvalid && rready |-> rdata == expRdata && rresp == expRresp)
		else abortRun($sformatf("ERR %0t: rdata %h rresp %0d, expected %h %0d",
			$time, rdata, rresp, expRdata, expRresp));
	assert property (@(posedge clk) disable iff (rst)
		bvalid && bready |-> bresp == expBresp)
		else abortRun($sformatf("ERR %0t: bresp %0d, expected %0d", $time, bresp, expBresp));
	assert property (@(posedge clk) disable iff (rst)
		(rvalid && !rready) || (bvalid && !bready) |=> $stable({rvalid, rdata, rresp, bvalid, bresp}))
		else abortRun($sformatf("ERR %0t: response changed before it was taken", $time));
	assert property (@(posedge clk) disable iff (rst)
		$past(arvalid && arready, 2) |-> $rose(rvalid))
		else abortRun($sformatf("ERR %0t: rvalid not two cycles after the read handshake", $time));
	assert property (@(posedge clk) disable iff (rst)
		$past(awvalid && awready) |-> $rose(bvalid))
		else abortRun($sformatf("ERR %0t: bvalid not one cycle after the write handshake", $time));
	assert property (@(posedge clk) disable iff (rst)
		awready == wready)
		else abortRun($sformatf("ERR %0t: awready %b and wready %b differ",
			$time, awready, wready));

	initial
	begin
		repeat (TestPhases * PhaseCycles) @(posedge clk);
		abortRun("Timeout: the watchdog ran out before the tests finished");
	end

	initial
	begin
		int idx;
		void'($urandom(32'h2a87));
		{awvalid, wvalid, arvalid, bready, rready, resetReq} <= '0;
		{awaddr, araddr, wdata, wstrb} <= '0;

		for (int i = 0; i < 20; i++)
			busTransfer(1'b1, axiAddrT'(i * 4), '0, '0, 0); // Factory contents.

		// Random writes, some of them over the boot image, each read back.
		for (int i = 0; i < 200; i++)
		begin
			idx = int'($urandom_range(DiskWords - 1));
			if (i % 8 == 0)
				idx = idx % BootWords;
			touched.push_back(idx);
			busTransfer(1'b0, axiAddrT'(idx * 4), $urandom, 4'hf, 0);
			busTransfer(1'b1, axiAddrT'($urandom_range(DiskWords - 1) * 4), '0, '0, 0);
			busTransfer(1'b1, axiAddrT'(idx * 4), '0, '0, 0);
		end

		@(posedge clk);
		resetReq <= 1'b1;
		@(posedge clk);
		resetReq <= 1'b0;
		model.delete(); // The written map is swept on reset.
		foreach (touched[k])
			busTransfer(1'b1, axiAddrT'(touched[k] * 4), '0, '0, 0);

		busTransfer(1'b0, 32'h0000_000c, 32'hdead_beef, 4'b0111, 0);
		busTransfer(1'b0, 32'h0000_1000, 32'h1234_5678, 4'hf, 0);
		busTransfer(1'b0, 32'h0000_0082, 32'h1234_5678, 4'hf, 0);
		busTransfer(1'b1, 32'h0000_0080, '0, '0, 0);
		busTransfer(1'b1, 32'h0000_000c, '0, '0, 0); // Store read data is now nonzero.
		busTransfer(1'b1, 32'hffff_fff0, '0, '0, 0);
		busTransfer(1'b1, 32'h0000_0013, '0, '0, 0);

		for (int i = 0; i < 24; i++)
		begin
			idx = int'($urandom_range(DiskWords - 1));
			busTransfer(1'b0, axiAddrT'(idx * 4), $urandom, 4'hf, int'($urandom_range(7)));
			busTransfer(1'b1, axiAddrT'(idx * 4), '0, '0, int'($urandom_range(7)));
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

/* sim.f */
hw/diskGeomPkg.sv
hw/diskBusPkg.sv
hw/diskReqIf.sv
hw/bootImageRom.sv
hw/writtenMap.sv
hw/sectorStore.sv
hw/axiLiteSlave.sv
hw/diskTop.sv
tests/tbClock.sv
tests/diskTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= diskTb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert
PASS_TEXT ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
